/* common/dcache_lookup_if.sv */
// Interface for data cache lookup results passed to the execute stage
`timescale 1ns/1ps

interface dcache_lookup_if;
    import lsu_pkg::*;

    logic       hit;
    data_t      word;
    logic       victim_valid;
    logic       victim_dirty;
    addr_t      victim_addr;
    cacheline_t victim_line;

    // Cache produces results for the op in the arbiter register
    modport cache (
        output hit,
        output word,
        output victim_valid,
        output victim_dirty,
        output victim_addr,
        output victim_line
    );

    modport ex (
        input hit,
        input word,
        input victim_valid,
        input victim_dirty,
        input victim_addr,
        input victim_line
    );

endinterface

/* common/lsu_pkg.sv */
// LSU localparams, operation enum, data types and the pipeline operation struct
package lsu_pkg;

    // Datapath widths
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int WORD_BYTES = DATA_WIDTH / 8;
    localparam int LINE_WORDS = 4;
    localparam int LINE_WIDTH = DATA_WIDTH * LINE_WORDS;

    // Direct-mapped data cache geometry
    localparam int DC_SETS         = 8;
    localparam int BYTE_SEL_WIDTH  = $clog2(WORD_BYTES);
    localparam int WORD_SEL_WIDTH  = $clog2(LINE_WORDS);
    localparam int DC_OFFSET_WIDTH = WORD_SEL_WIDTH + BYTE_SEL_WIDTH;
    localparam int DC_INDEX_WIDTH  = $clog2(DC_SETS);
    localparam int DC_TAG_WIDTH    = ADDR_WIDTH - DC_INDEX_WIDTH - DC_OFFSET_WIDTH;

    // Bus tag and queue sizes
    localparam int TAG_WIDTH = 6;
    localparam int LQ_DEPTH  = 8;
    localparam int SQ_DEPTH  = 8;

    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        FILL
    } lsu_func_t;

    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [LINE_WIDTH-1:0]     cacheline_t;
    typedef logic [TAG_WIDTH-1:0]      cdb_tag_t;
    typedef logic [LQ_DEPTH-1:0]       lq_select_t;
    typedef logic [SQ_DEPTH-1:0]       sq_select_t;
    typedef logic [DC_TAG_WIDTH-1:0]   dc_tag_t;
    typedef logic [DC_INDEX_WIDTH-1:0] dc_index_t;

    // One operation as it moves down the pipe
    typedef struct packed {
        lsu_func_t  func;
        lq_select_t lq_select;
        sq_select_t sq_select;
        cdb_tag_t   tag;
        addr_t      addr;
        data_t      data;
        cacheline_t line;
        logic       retire;
    } lsu_op_t;

endpackage

/* dcache/dcache_array.sv */
// Direct-mapped data cache arrays with lookup, store write and line fill
`timescale 1ns/1ps

module dcache_array (
    input  logic             clk,
    input  logic             n_rst,

    input  logic             i_valid,
    input  lsu_pkg::lsu_op_t i_op,

    dcache_lookup_if.cache   o_lookup
);
    import lsu_pkg::*;

    dc_tag_t                   tag_q  [DC_SETS];
    cacheline_t                line_q [DC_SETS];
    logic [DC_SETS-1:0]        valid_q;
    logic [DC_SETS-1:0]        dirty_q;

    dc_index_t                 index;
    dc_tag_t                   addr_tag;
    logic [WORD_SEL_WIDTH-1:0] word_sel;
    logic [BYTE_SEL_WIDTH-1:0] byte_sel;
    data_t                     cur_word;
    logic                      is_fill;
    logic                      is_store;
    logic                      fill_we;
    logic                      store_we;
    logic [WORD_BYTES-1:0]     lane_mask;
    data_t                     store_word;
    data_t                     merged_word;
    cacheline_t                merged_line;

    // Address split: tag 31:7, index 6:4, word 3:2, byte 1:0
    assign byte_sel = i_op.addr[BYTE_SEL_WIDTH-1:0];
    assign word_sel = i_op.addr[BYTE_SEL_WIDTH +: WORD_SEL_WIDTH];
    assign index    = i_op.addr[DC_OFFSET_WIDTH +: DC_INDEX_WIDTH];
    assign addr_tag = i_op.addr[ADDR_WIDTH-1 -: DC_TAG_WIDTH];

    assign is_fill  = i_op.func == FILL;
    assign is_store = (i_op.func == SB) | (i_op.func == SH) | (i_op.func == SW);

    assign cur_word = line_q[index][word_sel*DATA_WIDTH +: DATA_WIDTH];

    // Lookup results
    assign o_lookup.hit          = valid_q[index] && (tag_q[index] == addr_tag);
    assign o_lookup.word         = cur_word >> {byte_sel, 3'b000};
    assign o_lookup.victim_valid = valid_q[index];
    assign o_lookup.victim_dirty = dirty_q[index];
    assign o_lookup.victim_addr  = {tag_q[index], index, {DC_OFFSET_WIDTH{1'b0}}};
    assign o_lookup.victim_line  = line_q[index];

    assign fill_we  = i_valid & is_fill;
    assign store_we = i_valid & is_store & i_op.retire & o_lookup.hit;

    // Byte lanes touched by the store
    always_comb begin
        case (i_op.func)
            SB:      lane_mask = WORD_BYTES'(1);
            SH:      lane_mask = WORD_BYTES'(3);
            SW:      lane_mask = '1;
            default: lane_mask = '0;
        endcase
        lane_mask = lane_mask << byte_sel;
    end

    assign store_word = i_op.data << {byte_sel, 3'b000};

    always_comb begin
        merged_word = cur_word;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (lane_mask[b]) begin
                merged_word[b*8 +: 8] = store_word[b*8 +: 8];
            end
        end
        merged_line = line_q[index];
        merged_line[word_sel*DATA_WIDTH +: DATA_WIDTH] = merged_word;
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_q[index]  <= addr_tag;
            line_q[index] <= i_op.line;
        end else if (store_we) begin
            line_q[index] <= merged_line;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_we) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (store_we) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // Memory only fills lines that are not already resident
    a_no_redundant_fill: assert property (
        @(posedge clk) disable iff (!n_rst)
        (i_valid && is_fill) |-> !o_lookup.hit
    );

endmodule

/* design/lsu_arbiter.sv */
// Arbiter between line fills and queue operations with pipeline register
`timescale 1ns/1ps

module lsu_arbiter (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                i_flush,

    // Operation from the load/store queues
    input  logic                i_op_en,
    input  lsu_pkg::lsu_op_t    i_op,

    // Line fill from memory
    input  logic                i_fill_en,
    input  lsu_pkg::addr_t      i_fill_addr,
    input  lsu_pkg::cacheline_t i_fill_line,

    output logic                o_op_stall,
    output logic                o_valid,
    output lsu_pkg::lsu_op_t    o_op
);
    import lsu_pkg::*;

    lsu_op_t fill_op;
    lsu_op_t win_op;

    // Queue must hold its op while a fill owns the cache
    assign o_op_stall = i_fill_en & i_op_en;

    always_comb begin
        fill_op           = '0;
        fill_op.func      = FILL;
        fill_op.addr      = i_fill_addr;
        fill_op.line      = i_fill_line;
    end

    // Fill always has priority
    assign win_op = i_fill_en ? fill_op : i_op;

    always_ff @(posedge clk) begin
        if (!n_rst || i_flush) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_fill_en | i_op_en;
        end
    end

    always_ff @(posedge clk) begin
        o_op <= win_op;
    end

    // A fill, and so any stalled cycle, always reaches the cache next cycle
    a_fill_not_lost: assert property (
        @(posedge clk) disable iff (!n_rst)
        (i_fill_en && !i_flush) |=> (o_valid && o_op.func == FILL)
    );

endmodule

/* design/lsu_ex.sv */
// Execute stage with load extension, bus broadcast, queue update and victim output
`timescale 1ns/1ps

module lsu_ex (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,

    input  logic                 i_valid,
    input  lsu_pkg::lsu_op_t     i_op,
    dcache_lookup_if.ex          i_lookup,

    // Common data bus
    output logic                 o_valid,
    output lsu_pkg::data_t       o_data,
    output lsu_pkg::addr_t       o_addr,
    output lsu_pkg::cdb_tag_t    o_tag,

    // Queue updates
    output logic                 o_update_lq_en,
    output lsu_pkg::lq_select_t  o_update_lq_select,
    output logic                 o_update_lq_retry,
    output logic                 o_update_sq_en,
    output lsu_pkg::sq_select_t  o_update_sq_select,
    output logic                 o_update_sq_retry,

    // Dirty victim out to memory
    output logic                 o_victim_en,
    output lsu_pkg::addr_t       o_victim_addr,
    output lsu_pkg::cacheline_t  o_victim_line
);
    import lsu_pkg::*;

    logic  is_fill;
    logic  is_store;
    logic  is_load;
    logic  live;
    data_t load_data;

    assign is_fill  = i_op.func == FILL;
    assign is_store = (i_op.func == SB) | (i_op.func == SH) | (i_op.func == SW);
    assign is_load  = ~is_fill & ~is_store;
    assign live     = i_valid & ~i_flush;

    // Word from the cache is already byte aligned
    always_comb begin
        case (i_op.func)
            LB:      load_data = {{(DATA_WIDTH-8){i_lookup.word[7]}}, i_lookup.word[7:0]};
            LH:      load_data = {{(DATA_WIDTH-16){i_lookup.word[15]}}, i_lookup.word[15:0]};
            LBU:     load_data = {{(DATA_WIDTH-8){1'b0}}, i_lookup.word[7:0]};
            LHU:     load_data = {{(DATA_WIDTH-16){1'b0}}, i_lookup.word[15:0]};
            default: load_data = i_lookup.word;
        endcase
    end

    always_ff @(posedge clk) begin
        o_data             <= load_data;
        o_addr             <= i_op.addr;
        o_tag              <= i_op.tag;
        o_update_lq_select <= i_op.lq_select;
        o_update_lq_retry  <= ~i_lookup.hit;
        o_update_sq_select <= i_op.sq_select;
        o_update_sq_retry  <= ~i_lookup.hit;
        o_victim_addr      <= i_lookup.victim_addr;
        o_victim_line      <= i_lookup.victim_line;
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_valid        <= 1'b0;
            o_update_lq_en <= 1'b0;
            o_update_sq_en <= 1'b0;
            o_victim_en    <= 1'b0;
        end else begin
            o_valid        <= live & ~is_fill & (i_lookup.hit | is_store);
            o_update_lq_en <= live & is_load;
            o_update_sq_en <= live & is_store & i_op.retire;
            // Only dirty lines go back to memory
            o_victim_en    <= live & is_fill & i_lookup.victim_valid & i_lookup.victim_dirty;
        end
    end

    a_single_queue_update: assert property (
        @(posedge clk) disable iff (!n_rst)
        !(o_update_lq_en && o_update_sq_en)
    );

endmodule

/* design/lsu_top.sv */
// LSU top level joining the arbiter, data cache and execute stage
`timescale 1ns/1ps

module lsu_top (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,

    // Queue operation
    input  logic                 i_op_en,
    input  lsu_pkg::lsu_func_t   i_op_func,
    input  lsu_pkg::lq_select_t  i_op_lq_select,
    input  lsu_pkg::sq_select_t  i_op_sq_select,
    input  lsu_pkg::cdb_tag_t    i_op_tag,
    input  lsu_pkg::addr_t       i_op_addr,
    input  lsu_pkg::data_t       i_op_data,
    input  logic                 i_op_retire,

    // Line fill
    input  logic                 i_fill_en,
    input  lsu_pkg::addr_t       i_fill_addr,
    input  lsu_pkg::cacheline_t  i_fill_line,

    output logic                 o_op_stall,

    output logic                 o_valid,
    output lsu_pkg::data_t       o_data,
    output lsu_pkg::addr_t       o_addr,
    output lsu_pkg::cdb_tag_t    o_tag,
    output logic                 o_update_lq_en,
    output lsu_pkg::lq_select_t  o_update_lq_select,
    output logic                 o_update_lq_retry,
    output logic                 o_update_sq_en,
    output lsu_pkg::sq_select_t  o_update_sq_select,
    output logic                 o_update_sq_retry,
    output logic                 o_victim_en,
    output lsu_pkg::addr_t       o_victim_addr,
    output lsu_pkg::cacheline_t  o_victim_line
);
    import lsu_pkg::*;

    lsu_op_t queue_op;
    lsu_op_t arb_op;
    logic    arb_valid;

    dcache_lookup_if lookup_if ();

    // Queue ops carry no line
    assign queue_op = '{
        func:      i_op_func,
        lq_select: i_op_lq_select,
        sq_select: i_op_sq_select,
        tag:       i_op_tag,
        addr:      i_op_addr,
        data:      i_op_data,
        line:      '0,
        retire:    i_op_retire
    };

    lsu_arbiter arbiter0 (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_flush     (i_flush),
        .i_op_en     (i_op_en),
        .i_op        (queue_op),
        .i_fill_en   (i_fill_en),
        .i_fill_addr (i_fill_addr),
        .i_fill_line (i_fill_line),
        .o_op_stall  (o_op_stall),
        .o_valid     (arb_valid),
        .o_op        (arb_op)
    );

    dcache_array dcache0 (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_valid  (arb_valid),
        .i_op     (arb_op),
        .o_lookup (lookup_if.cache)
    );

    lsu_ex ex0 (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_valid            (arb_valid),
        .i_op               (arb_op),
        .i_lookup           (lookup_if.ex),
        .o_valid            (o_valid),
        .o_data             (o_data),
        .o_addr             (o_addr),
        .o_tag              (o_tag),
        .o_update_lq_en     (o_update_lq_en),
        .o_update_lq_select (o_update_lq_select),
        .o_update_lq_retry  (o_update_lq_retry),
        .o_update_sq_en     (o_update_sq_en),
        .o_update_sq_select (o_update_sq_select),
        .o_update_sq_retry  (o_update_sq_retry),
        .o_victim_en        (o_victim_en),
        .o_victim_addr      (o_victim_addr),
        .o_victim_line      (o_victim_line)
    );

endmodule

/* filelist.f */
common/lsu_pkg.sv
common/dcache_lookup_if.sv
design/lsu_arbiter.sv
dcache/dcache_array.sv
design/lsu_ex.sv
design/lsu_top.sv
sim/lsu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the LSU simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
PASS_MSG='*** TEST PASSED ***'

verilator --binary --timing --assert -j 0 \
    --top-module lsu_tb \
    -Mdir obj_dir -o lsu_sim \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/lsu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "$PASS_MSG" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

/* sim/lsu_tb.sv */
// Testbench for lsu_top with LFSR stimulus, reference cache model, output checker and watchdog
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 8;
    // Upper bound on the operations issued below
    localparam int NUM_OPS      = 44;
    localparam int WATCHDOG_NS  = (NUM_OPS * 4 + RESET_CYCLES) * CLK_PERIOD;

    typedef struct packed {
        logic       valid;
        logic       chk_data;
        data_t      data;
        addr_t      addr;
        cdb_tag_t   tag;
        logic       lq_en;
        lq_select_t lq_sel;
        logic       lq_retry;
        logic       sq_en;
        sq_select_t sq_sel;
        logic       sq_retry;
        logic       vic_en;
        addr_t      vic_addr;
        cacheline_t vic_line;
    } expect_t;

    logic       clk;
    logic       n_rst;
    logic       i_flush;
    logic       i_op_en;
    lsu_func_t  i_op_func;
    lq_select_t i_op_lq_select;
    sq_select_t i_op_sq_select;
    cdb_tag_t   i_op_tag;
    addr_t      i_op_addr;
    data_t      i_op_data;
    logic       i_op_retire;
    logic       i_fill_en;
    addr_t      i_fill_addr;
    cacheline_t i_fill_line;
    logic       o_op_stall;
    logic       o_valid;
    data_t      o_data;
    addr_t      o_addr;
    cdb_tag_t   o_tag;
    logic       o_update_lq_en;
    lq_select_t o_update_lq_select;
    logic       o_update_lq_retry;
    logic       o_update_sq_en;
    sq_select_t o_update_sq_select;
    logic       o_update_sq_retry;
    logic       o_victim_en;
    addr_t      o_victim_addr;
    cacheline_t o_victim_line;

    // Reference cache state
    logic [24:0] m_tag  [DC_SETS];
    cacheline_t  m_line [DC_SETS];
    logic [7:0]  m_valid;
    logic [7:0]  m_dirty;

    expect_t     exp_q[$];
    logic [31:0] lfsr_q = 32'h73e0999b;
    int          op_count = 0;
    int          errors = 0;
    int          checks = 0;
    lsu_func_t   load_funcs[5] = '{LB, LH, LW, LBU, LHU};

    lsu_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic cacheline_t rand_line();
        return {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
    endfunction

    function automatic addr_t make_addr(logic [24:0] tag, logic [2:0] set, logic [3:0] off);
        return {tag, set, off};
    endfunction

    function automatic expect_t expected_result(lsu_op_t op, logic set_valid, logic set_dirty,
                                                logic [24:0] set_tag, cacheline_t set_line);
        expect_t e;
        logic    hit;
        int      w;
        int      b;
        data_t   raw;
        e   = '0;
        w   = int'(op.addr[3:2]);
        b   = int'(op.addr[1:0]);
        hit = set_valid && (set_tag == op.addr[31:7]);
        // Addressed byte lands in the low bits and bytes past the word read as zero
        raw = '0;
        for (int k = 0; k < 4; k++) begin
            if (b + k < 4) begin
                raw[k*8 +: 8] = set_line[(w*4 + b + k)*8 +: 8];
            end
        end
        case (op.func)
            FILL: begin
                e.vic_en   = set_valid & set_dirty;
                e.vic_addr = {set_tag, op.addr[6:4], 4'h0};
                e.vic_line = set_line;
            end
            SB, SH, SW: begin
                e.valid    = 1'b1;
                e.addr     = op.addr;
                e.tag      = op.tag;
                e.sq_en    = op.retire;
                e.sq_sel   = op.sq_select;
                e.sq_retry = ~hit;
            end
            default: begin
                e.valid    = hit;
                e.chk_data = hit;
                e.addr     = op.addr;
                e.tag      = op.tag;
                e.lq_en    = 1'b1;
                e.lq_sel   = op.lq_select;
                e.lq_retry = ~hit;
                case (op.func)
                    LB:      e.data = data_t'($signed(raw[7:0]));
                    LH:      e.data = data_t'($signed(raw[15:0]));
                    LBU:     e.data = data_t'(raw[7:0]);
                    LHU:     e.data = data_t'(raw[15:0]);
                    default: e.data = raw;
                endcase
            end
        endcase
        return e;
    endfunction

    task automatic update_model(lsu_op_t op);
        logic [2:0] set;
        int         w;
        int         b;
        int         n;
        set = op.addr[6:4];
        w   = int'(op.addr[3:2]);
        b   = int'(op.addr[1:0]);
        n   = (op.func == SB) ? 1 : (op.func == SH) ? 2 : 4;
        if (op.func == FILL) begin
            m_tag[set]   = op.addr[31:7];
            m_line[set]  = op.line;
            m_valid[set] = 1'b1;
            m_dirty[set] = 1'b0;
        end else if ((op.func == SB || op.func == SH || op.func == SW) && op.retire &&
                     m_valid[set] && m_tag[set] == op.addr[31:7]) begin
            for (int k = 0; k < n; k++) begin
                if (b + k < 4) begin
                    m_line[set][(w*4 + b + k)*8 +: 8] = op.data[k*8 +: 8];
                end
            end
            m_dirty[set] = 1'b1;
        end
    endtask

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_outputs(expect_t e);
        check_value("o_valid", 128'(o_valid), 128'(e.valid));
        check_value("o_update_lq_en", 128'(o_update_lq_en), 128'(e.lq_en));
        check_value("o_update_sq_en", 128'(o_update_sq_en), 128'(e.sq_en));
        check_value("o_victim_en", 128'(o_victim_en), 128'(e.vic_en));
        if (e.valid) begin
            check_value("o_addr", 128'(o_addr), 128'(e.addr));
            check_value("o_tag", 128'(o_tag), 128'(e.tag));
        end
        if (e.chk_data) begin
            check_value("o_data", 128'(o_data), 128'(e.data));
        end
        if (e.lq_en) begin
            check_value("o_update_lq_select", 128'(o_update_lq_select), 128'(e.lq_sel));
            check_value("o_update_lq_retry", 128'(o_update_lq_retry), 128'(e.lq_retry));
        end
        if (e.sq_en) begin
            check_value("o_update_sq_select", 128'(o_update_sq_select), 128'(e.sq_sel));
            check_value("o_update_sq_retry", 128'(o_update_sq_retry), 128'(e.sq_retry));
        end
        if (e.vic_en) begin
            check_value("o_victim_addr", 128'(o_victim_addr), 128'(e.vic_addr));
            check_value("o_victim_line", 128'(o_victim_line), 128'(e.vic_line));
        end
    endtask

    // Expected results enter at acceptance and leave two edges later
    always @(posedge clk) begin
        expect_t    e;
        lsu_op_t    op;
        logic [2:0] set;
        if (!n_rst) begin
            m_valid = '0;
            m_dirty = '0;
        end else begin
            compare_outputs(exp_q.pop_front());
            if (i_flush) begin
                exp_q[0] = '0;
            end
            e = '0;
            if (!i_flush && (i_fill_en || i_op_en)) begin
                op = '0;
                if (i_fill_en) begin
                    op.func = FILL;
                    op.addr = i_fill_addr;
                    op.line = i_fill_line;
                end else begin
                    op.func      = i_op_func;
                    op.lq_select = i_op_lq_select;
                    op.sq_select = i_op_sq_select;
                    op.tag       = i_op_tag;
                    op.addr      = i_op_addr;
                    op.data      = i_op_data;
                    op.retire    = i_op_retire;
                end
                set = op.addr[6:4];
                e   = expected_result(op, m_valid[set], m_dirty[set], m_tag[set], m_line[set]);
                update_model(op);
            end
            exp_q.push_back(e);
        end
    end

    task automatic set_op(lsu_func_t func, addr_t addr, data_t data, logic retire);
        i_op_en        <= 1'b1;
        i_op_func      <= func;
        i_op_addr      <= addr;
        i_op_data      <= data;
        i_op_retire    <= retire;
        i_op_tag       <= cdb_tag_t'(op_count);
        i_op_lq_select <= lq_select_t'(1) << op_count[2:0];
        i_op_sq_select <= sq_select_t'(1) << op_count[2:0];
        op_count++;
    endtask

    // Hold the op until an edge without stall
    task automatic wait_accept();
        @(posedge clk);
        while (o_op_stall) begin
            @(posedge clk);
        end
    endtask

    task automatic drive_idle();
        i_op_en   <= 1'b0;
        i_fill_en <= 1'b0;
        i_flush   <= 1'b0;
        @(posedge clk);
    endtask

    task automatic drive_fill(addr_t addr, cacheline_t line);
        i_op_en     <= 1'b0;
        i_flush     <= 1'b0;
        i_fill_en   <= 1'b1;
        i_fill_addr <= addr;
        i_fill_line <= line;
        @(posedge clk);
    endtask

    task automatic drive_op(lsu_func_t func, addr_t addr, data_t data, logic retire,
                            logic flush);
        set_op(func, addr, data, retire);
        i_fill_en <= 1'b0;
        i_flush   <= flush;
        wait_accept();
    endtask

    // Stalled op goes in on the edge right after the fill
    task automatic drive_op_with_fill(addr_t fill_addr, cacheline_t line, lsu_func_t func,
                                      addr_t addr);
        set_op(func, addr, '0, 1'b0);
        i_flush     <= 1'b0;
        i_fill_en   <= 1'b1;
        i_fill_addr <= fill_addr;
        i_fill_line <= line;
        @(posedge clk);
        check_value("o_op_stall", 128'(o_op_stall), 128'(1'b1));
        i_fill_en <= 1'b0;
        @(posedge clk);
        check_value("o_op_stall", 128'(o_op_stall), 128'(1'b0));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog timeout: the run did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [24:0] tag_a;
        logic [24:0] tag_c;
        logic [24:0] tag_d;
        n_rst          = 1'b0;
        i_flush        = 1'b0;
        i_op_en        = 1'b0;
        i_op_func      = LW;
        i_op_lq_select = '0;
        i_op_sq_select = '0;
        i_op_tag       = '0;
        i_op_addr      = '0;
        i_op_data      = '0;
        i_op_retire    = 1'b0;
        i_fill_en      = 1'b0;
        i_fill_addr    = '0;
        i_fill_line    = '0;
        exp_q.push_back('0);
        exp_q.push_back('0);
        tag_a = 25'(rand_bits(25));
        tag_c = 25'(rand_bits(25));
        tag_d = 25'(rand_bits(25));
        repeat (RESET_CYCLES) @(posedge clk);
        n_rst <= 1'b1;

        // Every load func at every byte offset of a filled line
        drive_fill(make_addr(tag_a, 3'd1, 4'h0), rand_line());
        for (int f = 0; f < 5; f++) begin
            for (int b = 0; b < 4; b++) begin
                drive_op(load_funcs[f], make_addr(tag_a, 3'd1, {2'(rand_bits(2)), 2'(b)}),
                         '0, 1'b0, 1'b0);
            end
        end

        // Misses on an empty set and on a tag mismatch
        drive_op(LW, make_addr(tag_a, 3'd2, 4'h4), '0, 1'b0, 1'b0);
        drive_op(LB, make_addr(tag_a ^ 25'h1, 3'd1, 4'h8), '0, 1'b0, 1'b0);

        // Stores, then loads of the merged words
        drive_op(SB, make_addr(tag_a, 3'd1, 4'h1), rand_bits(32), 1'b1, 1'b0);
        drive_op(SH, make_addr(tag_a, 3'd1, 4'h6), rand_bits(32), 1'b1, 1'b0);
        drive_op(SW, make_addr(tag_a, 3'd1, 4'h8), rand_bits(32), 1'b1, 1'b0);
        drive_op(LW, make_addr(tag_a, 3'd1, 4'h0), '0, 1'b0, 1'b0);
        drive_op(LW, make_addr(tag_a, 3'd1, 4'h4), '0, 1'b0, 1'b0);
        drive_op(LW, make_addr(tag_a, 3'd1, 4'h8), '0, 1'b0, 1'b0);
        drive_op(SW, make_addr(tag_a, 3'd1, 4'hc), rand_bits(32), 1'b0, 1'b0);
        drive_op(LW, make_addr(tag_a, 3'd1, 4'hc), '0, 1'b0, 1'b0);
        drive_op(SW, make_addr(tag_a, 3'd2, 4'h0), rand_bits(32), 1'b1, 1'b0);

        // Dirty victim, then fills over invalid and clean lines
        drive_fill(make_addr(tag_a ^ 25'h1, 3'd1, 4'h0), rand_line());
        drive_fill(make_addr(tag_c, 3'd3, 4'h0), rand_line());
        drive_fill(make_addr(tag_c ^ 25'h1, 3'd3, 4'h0), rand_line());

        // Flush kills the op in the cache stage and the one being accepted
        drive_op(SW, make_addr(tag_a ^ 25'h1, 3'd1, 4'h4), rand_bits(32), 1'b1, 1'b0);
        drive_op(LH, make_addr(tag_a ^ 25'h1, 3'd1, 4'h2), '0, 1'b0, 1'b1);
        drive_op(LBU, make_addr(tag_a ^ 25'h1, 3'd1, 4'h3), '0, 1'b0, 1'b0);

        // Load colliding with a fill of its own line
        drive_op_with_fill(make_addr(tag_d, 3'd4, 4'h0), rand_line(), LW,
                           make_addr(tag_d, 3'd4, 4'h8));

        repeat (3) drive_idle();
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
